// ==== include/cache_defines.svh ====
// Geometry and register map of the read-only cache
// Line words and line count must be powers of two
// Register offsets are word offsets on the config port

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Geometry
`define CACHE_XLEN        32   // Data and address width
`define CACHE_LINE_WORDS  4    // Words per line, 16 bytes
`define CACHE_LINES       16   // Direct mapped, one way

// Config register word offsets
`define CACHE_REG_CTRL    3'd0 // Bit 0 enable, bit 1 flush, bit 2 busy
`define CACHE_REG_BASE    3'd1 // Cacheable region base
`define CACHE_REG_MASK    3'd2 // Cacheable region mask
`define CACHE_REG_HITS    3'd3 // Saturating hit counter
`define CACHE_REG_MISSES  3'd4 // Saturating miss counter

`endif

// ==== rtl/cache_biu.sv ====
// Wishbone classic read master, one command at a time
// Line reads walk the words of the line in order, no wrap
// Beat and err reports are combinational from the bus inputs

`default_nettype none

module cache_biu (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_pkg::biu_cmd_e        biu_cmd_i,
  input  logic [cache_pkg::XLEN-1:0] cmd_adr_i,
  output cache_pkg::biu_rsp_t        biu_rsp_o,
  output cache_pkg::wb_m2s_t         mem_wb_o,
  input  cache_pkg::wb_s2m_t         mem_wb_i
);

  localparam int OFFS_W = cache_pkg::OFFS_W;

  logic                         cyc_q;     // Bus cycle open
  logic                         done_q;    // Done strobe after last beat
  logic [cache_pkg::WORD_W-1:0] beat_q;
  logic                         bus_ack, bus_err, last_beat;

  assign bus_ack   = cyc_q & mem_wb_i.ack;
  assign bus_err   = cyc_q & mem_wb_i.err;
  assign last_beat = (biu_cmd_i == cache_pkg::READ_WORD) | (&beat_q);

  ////////////////////////////////
  // Bus side
  always_comb
  begin
    mem_wb_o.cyc = cyc_q;
    mem_wb_o.stb = cyc_q;
    mem_wb_o.we  = 1'b0;                  // Reads only
    mem_wb_o.dat = '0;
    mem_wb_o.sel = 4'hf;
    if (biu_cmd_i == cache_pkg::READ_LINE)
      mem_wb_o.adr = {cmd_adr_i[cache_pkg::XLEN-1:OFFS_W], beat_q, 2'b00};
    else
      mem_wb_o.adr = cmd_adr_i;
  end

  // Report to the hit stage
  assign biu_rsp_o.beat_valid = bus_ack;
  assign biu_rsp_o.err        = bus_err;
  assign biu_rsp_o.done       = done_q | bus_err; // Err ends it at once
  assign biu_rsp_o.beat       = beat_q;
  assign biu_rsp_o.data       = mem_wb_i.dat;

  ////////////////////////////////
  // Sequencer
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
      beat_q <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (!cyc_q)
      begin
        // Command drops to NOP together with done
        if (!done_q && biu_cmd_i != cache_pkg::NOP)
        begin
          cyc_q  <= 1'b1;
          beat_q <= '0;
        end
      end
      else if (bus_err)
        cyc_q <= 1'b0;                    // Abort, rest of line dropped
      else if (bus_ack)
      begin
        if (last_beat)
        begin
          cyc_q  <= 1'b0;
          done_q <= 1'b1;
        end
        else
          beat_q <= beat_q + 1'b1;        // Next word, stb stays up
      end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_cfg_regs.sv ====
// Config slave, Wishbone classic, one wait state per access
// Offsets above MISSES answer with err
// Counters saturate at all ones and clear on any write

`default_nettype none

`include "cache_defines.svh"

module cache_cfg_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  cache_pkg::wb_m2s_t        cfg_wb_i,
  output cache_pkg::wb_s2m_t        cfg_wb_o,
  input  logic                      hit_pulse_i,
  input  logic                      miss_pulse_i,
  input  logic                      flush_done_i,
  output logic                      enable_o,
  output logic [cache_pkg::XLEN-1:0] region_base_o,
  output logic [cache_pkg::XLEN-1:0] region_mask_o,
  output logic                      flush_req_o
);

  logic                       ack_q, err_q;
  logic                       busy_q;
  logic [cache_pkg::XLEN-1:0] hits_q, misses_q;
  logic [2:0]                 reg_off;
  logic                       access, known, wr;

  assign reg_off = cfg_wb_i.adr[4:2];            // Word offset
  assign access  = cfg_wb_i.cyc & cfg_wb_i.stb & ~ack_q & ~err_q; // Gap after each ack
  assign known   = reg_off <= `CACHE_REG_MISSES;
  assign wr      = access & known & cfg_wb_i.we;

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      ack_q         <= 1'b0;
      err_q         <= 1'b0;
      enable_o      <= 1'b1;
      region_base_o <= '0;
      region_mask_o <= 32'hffff_0000;
      flush_req_o   <= 1'b0;
      busy_q        <= 1'b0;
      hits_q        <= '0;
      misses_q      <= '0;
    end
    else
    begin
      ack_q       <= access & known;
      err_q       <= access & ~known;
      flush_req_o <= 1'b0;                        // Single cycle strobe

      if (flush_done_i) busy_q <= 1'b0;
      if (hit_pulse_i && hits_q != '1) hits_q <= hits_q + 1'b1;
      if (miss_pulse_i && misses_q != '1) misses_q <= misses_q + 1'b1;

      ////////////////////////////////
      // Register writes
      if (wr)
        case (reg_off)
          `CACHE_REG_CTRL:
          begin
            enable_o <= cfg_wb_i.dat[0];
            if (cfg_wb_i.dat[1])
            begin
              flush_req_o <= 1'b1;
              busy_q      <= 1'b1;                // Until walker ends
            end
          end
          `CACHE_REG_BASE:   region_base_o <= cfg_wb_i.dat;
          `CACHE_REG_MASK:   region_mask_o <= cfg_wb_i.dat;
          `CACHE_REG_HITS:   hits_q        <= '0; // Write clears
          `CACHE_REG_MISSES: misses_q      <= '0;
          default: ;
        endcase
    end

  // Read mux, master holds adr until ack
  always_comb
  begin
    cfg_wb_o.ack = ack_q;
    cfg_wb_o.err = err_q;
    case (reg_off)
      `CACHE_REG_CTRL:   cfg_wb_o.dat = {29'd0, busy_q, 1'b0, enable_o};
      `CACHE_REG_BASE:   cfg_wb_o.dat = region_base_o;
      `CACHE_REG_MASK:   cfg_wb_o.dat = region_mask_o;
      `CACHE_REG_HITS:   cfg_wb_o.dat = hits_q;
      `CACHE_REG_MISSES: cfg_wb_o.dat = misses_q;
      default:           cfg_wb_o.dat = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/cache_hit.sv ====
// Hit stage, core held in stall until ack or err
// Hits answer in the request cycle, misses forward the critical beat
// A flush is only taken in ARMED, requests wait until it ends

`default_nettype none

module cache_hit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  cache_pkg::core_req_t          core_req_i,
  output cache_pkg::core_rsp_t          core_rsp_o,
  input  logic                          enable_i,
  input  logic [cache_pkg::XLEN-1:0]    region_base_i,
  input  logic [cache_pkg::XLEN-1:0]    region_mask_i,
  input  logic                          flush_req_i,
  input  logic                          flush_done_i,
  // Store read port
  output logic [cache_pkg::IDX_W-1:0]   rd_idx_o,
  output logic [cache_pkg::WORD_W-1:0]  rd_word_o,
  input  logic [cache_pkg::TAG_W-1:0]   tag_i,
  input  logic                          valid_i,
  input  logic [cache_pkg::XLEN-1:0]    data_i,
  // Store write port
  output logic                          wr_en_o,
  output logic [cache_pkg::IDX_W-1:0]   wr_idx_o,
  output logic [cache_pkg::WORD_W-1:0]  wr_word_o,
  output logic [cache_pkg::XLEN-1:0]    wr_data_o,
  output logic                          commit_o,
  output logic [cache_pkg::TAG_W-1:0]   commit_tag_o,
  // Bus interface unit
  output cache_pkg::biu_cmd_e           biu_cmd_o,
  output logic [cache_pkg::XLEN-1:0]    cmd_adr_o,
  input  cache_pkg::biu_rsp_t           biu_rsp_i,
  output logic                          hit_pulse_o,
  output logic                          miss_pulse_o
);

  localparam int OFFS_W = cache_pkg::OFFS_W;

  cache_pkg::hit_state_e  state_q;
  cache_pkg::addr_split_t adr, fill_adr;
  logic                   cacheable, line_hit;
  logic                   armed_req;
  logic                   early_ack;
  logic                   served_q;          // Fill word already given to core

  assign adr      = core_req_i.adr;
  assign fill_adr = cmd_adr_o;               // Core may move on after early ack

  assign cacheable = enable_i & ((core_req_i.adr & region_mask_i) == region_base_i);
  assign line_hit  = valid_i & (tag_i == adr.tag);
  assign armed_req = (state_q == cache_pkg::ARMED) & core_req_i.valid & ~flush_req_i;

  // Store lookup follows the core address
  assign rd_idx_o  = adr.idx;
  assign rd_word_o = adr.word;

  // Fill beats straight into the store
  assign wr_en_o      = (state_q == cache_pkg::FILL) & biu_rsp_i.beat_valid;
  assign wr_idx_o     = fill_adr.idx;
  assign wr_word_o    = biu_rsp_i.beat;
  assign wr_data_o    = biu_rsp_i.data;
  assign commit_o     = (state_q == cache_pkg::FILL) & biu_rsp_i.done & ~biu_rsp_i.err;
  assign commit_tag_o = fill_adr.tag;

  // Requested word on the bus, first one only
  assign early_ack = core_req_i.valid & ~served_q & biu_rsp_i.beat_valid &
                     (biu_rsp_i.beat == adr.word);

  assign hit_pulse_o  = armed_req & cacheable & line_hit;
  assign miss_pulse_o = armed_req & cacheable & ~line_hit;

  ////////////////////////////////
  // Core response
  always_comb
  begin
    core_rsp_o.ack  = 1'b0;
    core_rsp_o.err  = 1'b0;
    core_rsp_o.data = biu_rsp_i.data;        // Bus data unless hit
    case (state_q)
      cache_pkg::ARMED:
      begin
        core_rsp_o.ack  = hit_pulse_o;
        core_rsp_o.data = data_i;
      end
      cache_pkg::NONCACHEABLE:
      begin
        core_rsp_o.ack = biu_rsp_i.beat_valid;
        core_rsp_o.err = biu_rsp_i.err;
      end
      cache_pkg::FILL:
      begin
        core_rsp_o.ack = early_ack;
        core_rsp_o.err = biu_rsp_i.err & ~served_q; // Not for a later request
      end
      default: ;
    endcase
  end

  ////////////////////////////////
  // State machine
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state_q   <= cache_pkg::ARMED;
      biu_cmd_o <= cache_pkg::NOP;
      served_q  <= 1'b0;
    end
    else
      case (state_q)
        cache_pkg::ARMED:
          if (flush_req_i) state_q <= cache_pkg::FLUSH;
          else if (armed_req && !cacheable)
          begin
            state_q   <= cache_pkg::NONCACHEABLE;
            biu_cmd_o <= cache_pkg::READ_WORD;
          end
          else if (miss_pulse_o)
          begin
            state_q   <= cache_pkg::FILL;
            biu_cmd_o <= cache_pkg::READ_LINE;
            served_q  <= 1'b0;
          end
        cache_pkg::FLUSH:
          if (flush_done_i) state_q <= cache_pkg::RECOVER;
        cache_pkg::NONCACHEABLE:
          if (biu_rsp_i.done)
          begin
            state_q   <= cache_pkg::ARMED;
            biu_cmd_o <= cache_pkg::NOP;
          end
        cache_pkg::FILL:
        begin
          if (early_ack) served_q <= 1'b1;
          if (biu_rsp_i.done)
          begin
            state_q   <= cache_pkg::RECOVER; // Store settles the new line
            biu_cmd_o <= cache_pkg::NOP;
          end
        end
        default: state_q <= cache_pkg::ARMED; // RECOVER
      endcase

  // Bus address, held with the command
  always_ff @(posedge clk_i)
    if (armed_req)
      cmd_adr_o <= cacheable ? {core_req_i.adr[cache_pkg::XLEN-1:OFFS_W], {OFFS_W{1'b0}}}
                             : {core_req_i.adr[cache_pkg::XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

// ==== rtl/cache_pkg.sv ====
// Shared types of the cache subsystem
// Field widths follow the geometry macros

`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

  localparam int XLEN   = `CACHE_XLEN;
  localparam int WORDS  = `CACHE_LINE_WORDS;
  localparam int LINES  = `CACHE_LINES;
  localparam int IDX_W  = $clog2(LINES);
  localparam int WORD_W = $clog2(WORDS);
  localparam int OFFS_W = WORD_W + 2;         // Word plus byte offset
  localparam int TAG_W  = XLEN - IDX_W - OFFS_W;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] word;
    logic [1:0]        byte_off;
  } addr_split_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] adr;
  } core_req_t;

  typedef struct packed {
    logic            ack;
    logic            err;
    logic [XLEN-1:0] data;
  } core_rsp_t;

  typedef enum logic [1:0] {NOP, READ_LINE, READ_WORD} biu_cmd_e;

  typedef struct packed {
    logic              beat_valid; // Data valid this cycle
    logic              done;       // Transfer over
    logic              err;        // Bus error, ends transfer
    logic [WORD_W-1:0] beat;
    logic [XLEN-1:0]   data;
  } biu_rsp_t;

  // Wishbone classic bundles
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    logic [3:0]      sel;
  } wb_m2s_t;

  typedef struct packed {
    logic            ack;
    logic            err;
    logic [XLEN-1:0] dat;
  } wb_s2m_t;

  typedef enum logic [2:0] {ARMED, FLUSH, NONCACHEABLE, FILL, RECOVER} hit_state_e;

endpackage

`default_nettype wire

// ==== rtl/cache_store.sv ====
// Direct mapped tag, valid and data arrays, reads are combinational
// Any beat write drops the line's valid bit until the commit
// Flush walker clears one line per cycle, line count a power of two

`default_nettype none

module cache_store (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [cache_pkg::IDX_W-1:0]  rd_idx_i,
  input  logic [cache_pkg::WORD_W-1:0] rd_word_i,
  output logic [cache_pkg::TAG_W-1:0]  tag_o,
  output logic                         valid_o,
  output logic [cache_pkg::XLEN-1:0]   data_o,
  input  logic                         wr_en_i,
  input  logic [cache_pkg::IDX_W-1:0]  wr_idx_i,
  input  logic [cache_pkg::WORD_W-1:0] wr_word_i,
  input  logic [cache_pkg::XLEN-1:0]   wr_data_i,
  input  logic                         commit_i,
  input  logic [cache_pkg::TAG_W-1:0]  commit_tag_i,
  input  logic                         flush_req_i,
  output logic                         flush_done_o
);

  logic [cache_pkg::XLEN-1:0]  data_q [cache_pkg::LINES][cache_pkg::WORDS];
  logic [cache_pkg::TAG_W-1:0] tag_q  [cache_pkg::LINES];
  logic [cache_pkg::LINES-1:0] valid_q;

  logic                        walk_q;   // Walker busy
  logic [cache_pkg::IDX_W-1:0] walk_idx_q;

  // Lookup
  assign tag_o   = tag_q[rd_idx_i];
  assign valid_o = valid_q[rd_idx_i];
  assign data_o  = data_q[rd_idx_i][rd_word_i];

  assign flush_done_o = walk_q & (&walk_idx_q); // Last line this cycle

  //////////////////////////////
  // Payload arrays
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i) data_q[wr_idx_i][wr_word_i] <= wr_data_i;
    if (commit_i) tag_q[wr_idx_i] <= commit_tag_i;
  end

  //////////////////////////////
  // Valid bits and walker
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      valid_q    <= '0;
      walk_q     <= 1'b0;
      walk_idx_q <= '0;
    end
    else
    begin
      if (wr_en_i) valid_q[wr_idx_i] <= 1'b0; // Partly overwritten line
      if (commit_i) valid_q[wr_idx_i] <= 1'b1;

      if (flush_req_i)
      begin
        walk_q     <= 1'b1;                    // (Re)start at line 0
        walk_idx_q <= '0;
      end
      else if (walk_q)
      begin
        valid_q[walk_idx_q] <= 1'b0;
        walk_idx_q          <= walk_idx_q + 1'b1;
        if (&walk_idx_q) walk_q <= 1'b0;
      end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
// Read-only cache subsystem, core port in front, Wishbone behind
// Config slave sits beside the hit stage on its own bus

`default_nettype none

module cache_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cache_pkg::core_req_t core_req_i,
  output cache_pkg::core_rsp_t core_rsp_o,
  output cache_pkg::wb_m2s_t   mem_wb_o,
  input  cache_pkg::wb_s2m_t   mem_wb_i,
  input  cache_pkg::wb_m2s_t   cfg_wb_i,
  output cache_pkg::wb_s2m_t   cfg_wb_o
);

  // Config
  logic                         enable;
  logic [cache_pkg::XLEN-1:0]   region_base, region_mask;
  logic                         flush_req, flush_done;
  logic                         hit_pulse, miss_pulse;

  // Store ports
  logic [cache_pkg::IDX_W-1:0]  rd_idx, wr_idx;
  logic [cache_pkg::WORD_W-1:0] rd_word, wr_word;
  logic [cache_pkg::TAG_W-1:0]  tag, commit_tag;
  logic                         valid, wr_en, commit;
  logic [cache_pkg::XLEN-1:0]   rd_data, wr_data;

  // Bus interface
  cache_pkg::biu_cmd_e          biu_cmd;
  logic [cache_pkg::XLEN-1:0]   cmd_adr;
  cache_pkg::biu_rsp_t          biu_rsp;

  cache_cfg_regs cache_cfg_regs_inst (
    .clk_i, .rst_ni, .cfg_wb_i, .cfg_wb_o,
    .hit_pulse_i   (hit_pulse),
    .miss_pulse_i  (miss_pulse),
    .flush_done_i  (flush_done),
    .enable_o      (enable),
    .region_base_o (region_base),
    .region_mask_o (region_mask),
    .flush_req_o   (flush_req)
  );

  cache_store cache_store_inst (
    .clk_i, .rst_ni,
    .rd_idx_i (rd_idx), .rd_word_i (rd_word),
    .tag_o (tag), .valid_o (valid), .data_o (rd_data),
    .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_word_i (wr_word), .wr_data_i (wr_data),
    .commit_i (commit), .commit_tag_i (commit_tag),
    .flush_req_i (flush_req), .flush_done_o (flush_done) // Walk starts with cfg strobe
  );

  cache_hit cache_hit_inst (
    .clk_i, .rst_ni, .core_req_i, .core_rsp_o,
    .enable_i (enable), .region_base_i (region_base), .region_mask_i (region_mask),
    .flush_req_i (flush_req), .flush_done_i (flush_done),
    .rd_idx_o (rd_idx), .rd_word_o (rd_word),
    .tag_i (tag), .valid_i (valid), .data_i (rd_data),
    .wr_en_o (wr_en), .wr_idx_o (wr_idx), .wr_word_o (wr_word), .wr_data_o (wr_data),
    .commit_o (commit), .commit_tag_o (commit_tag),
    .biu_cmd_o (biu_cmd), .cmd_adr_o (cmd_adr), .biu_rsp_i (biu_rsp),
    .hit_pulse_o (hit_pulse), .miss_pulse_o (miss_pulse)
  );

  cache_biu cache_biu_inst (
    .clk_i, .rst_ni,
    .biu_cmd_i (biu_cmd), .cmd_adr_i (cmd_adr), .biu_rsp_o (biu_rsp),
    .mem_wb_o, .mem_wb_i
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f verilog.f \
  -o cache_sim || exit 1
sim_out="$(./obj_dir/cache_sim 2>&1)"
printf '%s\n' "$sim_out"
grep -qF "Simulation finished: PASS" <<< "$sim_out" && exit 0 || exit 1

// ==== sim/cache_sva.sv ====
// Handshake checks on the memory bus, the core response and the BIU command
// Bound into cache_top, every property idle during reset

`default_nettype none

module cache_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input cache_pkg::wb_m2s_t   mem_wb_m2s_i,
  input cache_pkg::wb_s2m_t   mem_wb_s2m_i,
  input cache_pkg::core_rsp_t core_rsp_i,
  input cache_pkg::biu_cmd_e  biu_cmd_i,
  input cache_pkg::biu_rsp_t  biu_rsp_i
);

  // Strobe and address held until the slave answers
  stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_wb_m2s_i.stb && !mem_wb_s2m_i.ack && !mem_wb_s2m_i.err
    |=> mem_wb_m2s_i.cyc && mem_wb_m2s_i.stb && $stable(mem_wb_m2s_i.adr))
    else $error("memory stb dropped or address moved before ack");

  // Core sees either data or an error, never both
  rsp_ack_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_rsp_i.ack && core_rsp_i.err))
    else $error("core ack and err high together");

  // Command only changes after done
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_cmd_i != cache_pkg::NOP && !biu_rsp_i.done |=> $stable(biu_cmd_i))
    else $error("biu_cmd changed before done");

endmodule

bind cache_top cache_sva cache_sva_inst (
  .clk_i, .rst_ni,
  .mem_wb_m2s_i (mem_wb_o), .mem_wb_s2m_i (mem_wb_i),
  .core_rsp_i (core_rsp_o),
  .biu_cmd_i (biu_cmd), .biu_rsp_i (biu_rsp)
);

`default_nettype wire

// ==== sim/cache_tb.sv ====
// Testbench for the read-only cache, one table row applied at a time
// Memory answers adr ^ 5a5a_0000 after 0 to 3 random wait states
// Addresses from dead_0000 upward answer with a bus error
// First failing check ends the run

`default_nettype none

`include "cache_defines.svh"

module cache_tb;

  typedef enum logic [1:0] {OP_READ, OP_CFG_WR, OP_CFG_RD, OP_POLL} op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [31:0] adr;        // Core address or register offset
    logic [31:0] wdata;
    logic [31:0] exp;        // Read data or register value
    logic        exp_err;
    logic [7:0]  exp_reads;  // Memory read cycles for the row
  } op_t;

  logic                clk_i;
  logic                rst_ni;
  cache_pkg::core_req_t core_req;
  cache_pkg::core_rsp_t core_rsp;
  cache_pkg::wb_m2s_t  mem_wb_m2s, cfg_wb_m2s;
  cache_pkg::wb_s2m_t  mem_wb_s2m, cfg_wb_s2m;

  op_t ops[$];
  int  num_rows  = 0;
  int  mem_reads = 0;        // Every answered memory read, ack or err
  int  mem_wait;
  logic mem_busy = 1'b0;
  int  seed_dummy;

  cache_top cache_top_inst (
    .clk_i, .rst_ni,
    .core_req_i (core_req), .core_rsp_o (core_rsp),
    .mem_wb_o (mem_wb_m2s), .mem_wb_i (mem_wb_s2m),
    .cfg_wb_i (cfg_wb_m2s), .cfg_wb_o (cfg_wb_s2m)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return adr ^ 32'h5a5a_0000;
  endfunction

  //////////////////////////////
  // Memory model, Wishbone classic slave
  always @(posedge clk_i)
  begin
    mem_wb_s2m.ack <= 1'b0;          // Single cycle ack
    mem_wb_s2m.err <= 1'b0;
    if (mem_wb_m2s.cyc && mem_wb_m2s.stb && !mem_wb_s2m.ack && !mem_wb_s2m.err)
    begin
      if (!mem_busy)
      begin
        mem_busy = 1'b1;             // New access, pick its wait states
        mem_wait = $urandom % 4;
      end
      if (mem_wait != 0)
        mem_wait = mem_wait - 1;
      else
      begin
        mem_busy  = 1'b0;
        mem_reads = mem_reads + 1;
        if (mem_wb_m2s.we || mem_wb_m2s.sel !== 4'hf)
          stop_with_error("memory access is not a full-word read");
        if (mem_wb_m2s.adr >= 32'hdead_0000)
          mem_wb_s2m.err <= 1'b1;
        else
        begin
          mem_wb_s2m.ack <= 1'b1;
          mem_wb_s2m.dat <= mem_word(mem_wb_m2s.adr);
        end
      end
    end
  end

  //////////////////////////////
  // Failure reporting and checks
  task automatic stop_with_error(input string reason);
    $display("Error: %s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_rsp(input string name, input cache_pkg::core_rsp_t got,
                           input cache_pkg::core_rsp_t exp);
    if (got.ack !== exp.ack || got.err !== exp.err || (exp.ack && got.data !== exp.data))
    begin
      $display("Mismatch at time %0t: %s got ack %b err %b data %h, expected ack %b err %b data %h",
               $time, name, got.ack, got.err, got.data, exp.ack, exp.err, exp.data);
      stop_with_error("core response differs from the expected one");
    end
  endtask

  task automatic check_cfg(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
      stop_with_error("config register differs from the expected value");
    end
  endtask

  task automatic check_bus_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("Mismatch at time %0t: %s got %0d, expected %0d", $time, name, got, exp);
      stop_with_error("wrong number of memory read cycles");
    end
  endtask

  //////////////////////////////
  // Bus drivers
  task automatic core_read(input logic [31:0] adr, output cache_pkg::core_rsp_t rsp);
    cache_pkg::core_req_t req;
    req.valid = 1'b1;
    req.adr   = adr;
    @(posedge clk_i);
    core_req <= req;
    do @(negedge clk_i); while (!core_rsp.ack && !core_rsp.err);
    rsp = core_rsp;
    @(posedge clk_i);
    core_req <= '0;                  // Request held until answered
  endtask

  task automatic cfg_access(input logic we, input logic [2:0] off, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    cache_pkg::wb_m2s_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = {27'd0, off, 2'b00};
    req.dat = wdata;
    req.sel = 4'hf;
    @(posedge clk_i);
    cfg_wb_m2s <= req;
    do @(negedge clk_i); while (!cfg_wb_s2m.ack && !cfg_wb_s2m.err);
    if (cfg_wb_s2m.err) stop_with_error("config access answered with a bus error");
    rdata = cfg_wb_s2m.dat;
    @(posedge clk_i);
    cfg_wb_m2s <= '0;
  endtask

  task automatic poll_busy(output logic [31:0] ctrl);
    do cfg_access(1'b0, `CACHE_REG_CTRL, '0, ctrl); while (ctrl[2]);
  endtask

  task automatic table_row(input op_kind_e kind, input logic [31:0] adr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic exp_err, input int exp_reads);
    op_t row;
    row.kind      = kind;
    row.adr       = adr;
    row.wdata     = wdata;
    row.exp       = exp;
    row.exp_err   = exp_err;
    row.exp_reads = 8'(exp_reads);
    ops.push_back(row);
  endtask

  //////////////////////////////
  // Stimulus table
  task automatic build_table();
    // Miss fills the line, rest of line hits
    table_row(OP_READ, 32'h0000_0104, '0, mem_word(32'h0000_0104), 1'b0, 4);
    table_row(OP_READ, 32'h0000_010c, '0, mem_word(32'h0000_010c), 1'b0, 0);
    table_row(OP_READ, 32'h0000_0100, '0, mem_word(32'h0000_0100), 1'b0, 0);
    // Outside the region, memory every time
    table_row(OP_READ, 32'h0001_0000, '0, mem_word(32'h0001_0000), 1'b0, 1);
    table_row(OP_READ, 32'h0001_0000, '0, mem_word(32'h0001_0000), 1'b0, 1);
    // Counters and reset values
    table_row(OP_CFG_RD, `CACHE_REG_HITS, '0, 32'd2, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_MISSES, '0, 32'd1, 1'b0, 0);
    table_row(OP_CFG_WR, `CACHE_REG_HITS, '0, '0, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_HITS, '0, 32'd0, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_MISSES, '0, 32'd1, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_BASE, '0, 32'h0000_0000, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_MASK, '0, 32'hffff_0000, 1'b0, 0);
    // Flush, busy seen while the walk runs
    table_row(OP_CFG_WR, `CACHE_REG_CTRL, 32'h3, '0, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_CTRL, '0, 32'h5, 1'b0, 0);
    table_row(OP_POLL, `CACHE_REG_CTRL, '0, 32'h1, 1'b0, 0);
    table_row(OP_READ, 32'h0000_0108, '0, mem_word(32'h0000_0108), 1'b0, 4);
    table_row(OP_READ, 32'h0000_010c, '0, mem_word(32'h0000_010c), 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_MISSES, '0, 32'd2, 1'b0, 0);
    // Cache disabled
    table_row(OP_CFG_WR, `CACHE_REG_CTRL, 32'h0, '0, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_CTRL, '0, 32'h0, 1'b0, 0);
    table_row(OP_READ, 32'h0000_0108, '0, mem_word(32'h0000_0108), 1'b0, 1);
    table_row(OP_READ, 32'h0000_0108, '0, mem_word(32'h0000_0108), 1'b0, 1);
    table_row(OP_READ, 32'h0000_0200, '0, mem_word(32'h0000_0200), 1'b0, 1);
    table_row(OP_CFG_RD, `CACHE_REG_HITS, '0, 32'd1, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_MISSES, '0, 32'd2, 1'b0, 0);
    table_row(OP_CFG_WR, `CACHE_REG_CTRL, 32'h1, '0, 1'b0, 0);
    table_row(OP_READ, 32'h0000_0104, '0, mem_word(32'h0000_0104), 1'b0, 0);
    // Bus errors, uncached then a failed fill and its retry
    table_row(OP_READ, 32'hdead_0010, '0, '0, 1'b1, 1);
    table_row(OP_CFG_WR, `CACHE_REG_BASE, 32'hdead_0000, '0, 1'b0, 0);
    table_row(OP_READ, 32'hdead_0024, '0, '0, 1'b1, 1);
    table_row(OP_READ, 32'hdead_0024, '0, '0, 1'b1, 1);
    table_row(OP_CFG_RD, `CACHE_REG_MISSES, '0, 32'd4, 1'b0, 0);
    table_row(OP_CFG_RD, `CACHE_REG_HITS, '0, 32'd2, 1'b0, 0);
  endtask

  //////////////////////////////
  // Main sequence
  initial
  begin
    int                   i;
    int                   reads_before;
    op_t                  row;
    cache_pkg::core_rsp_t rsp, exp_rsp;
    logic [31:0]          rdata;
    seed_dummy = $urandom(32'h88c4_6af6);
    rst_ni     = 1'b0;
    core_req   = '0;
    cfg_wb_m2s = '0;
    mem_wb_s2m = '0;
    build_table();
    num_rows = ops.size();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (i = 0; i < num_rows; i++)
    begin
      row          = ops[i];
      reads_before = mem_reads;
      case (row.kind)
        OP_READ:
        begin
          core_read(row.adr, rsp);
          exp_rsp.ack  = ~row.exp_err;
          exp_rsp.err  = row.exp_err;
          exp_rsp.data = row.exp;
          check_rsp($sformatf("core_rsp row %0d", i), rsp, exp_rsp);
        end
        OP_CFG_WR: cfg_access(1'b1, row.adr[2:0], row.wdata, rdata);
        OP_CFG_RD:
        begin
          cfg_access(1'b0, row.adr[2:0], '0, rdata);
          check_cfg($sformatf("cfg_wb.dat row %0d", i), rdata, row.exp);
        end
        default:
        begin
          poll_busy(rdata);
          check_cfg($sformatf("ctrl after flush row %0d", i), rdata, row.exp);
        end
      endcase
      // Rest of a line fill runs on after the early ack
      do @(negedge clk_i); while (mem_wb_m2s.cyc);
      check_bus_count($sformatf("memory reads row %0d", i), mem_reads - reads_before,
                      int'(row.exp_reads));
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog, 200 cycles per row
  initial
  begin
    wait (num_rows > 0);
    repeat (200 * num_rows + 2) @(posedge clk_i);
    stop_with_error("watchdog expired, the DUT stopped answering");
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
rtl/cache_pkg.sv
rtl/cache_cfg_regs.sv
rtl/cache_store.sv
rtl/cache_hit.sv
rtl/cache_biu.sv
rtl/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv
